// File: rtl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // RV32I major opcodes, op_nop stands in for anything unsupported
    typedef enum logic [6:0] {
        op_nop   = 7'b0000000,
        op_load  = 7'b0000011,
        op_imm   = 7'b0010011,
        op_store = 7'b0100011,
        op_reg   = 7'b0110011,
        op_lui   = 7'b0110111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // operand source for the EX stage
    typedef enum logic [1:0] {
        no_fwd  = 2'b00,
        fwd_mem = 2'b01,
        fwd_wb  = 2'b10
    } fwd_sel_t;

endpackage

`default_nettype wire

// File: rtl/instr_decode.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decode
import pipe_pkg::*;
(
    input  word_t     instr_i,
    output reg_addr_t rs1_o,
    output reg_addr_t rs2_o,
    output reg_addr_t rd_o,
    output word_t     imm_o,
    output opcode_t   opcode_o,
    output alu_op_t   alu_op_o,
    output logic      use_imm_o,
    output logic      writes_rd_o,
    output logic      mem_read_o,
    output logic      mem_write_o
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_reg;
    word_t      imm_i_type;
    word_t      imm_s_type;
    word_t      imm_u_type;
    alu_op_t    alu_sel;
    logic       alu_ok;

    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign is_reg = (instr_i[6:0] == op_reg);

    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_u_type = {instr_i[31:12], 12'b0};

    // funct3/funct7 to ALU operation, shared by OP and OP-IMM
    always_comb begin
        case (funct3)
            3'b000:  alu_sel = (is_reg && funct7[5]) ? alu_sub : alu_add;
            3'b001:  alu_sel = alu_sll;
            3'b010:  alu_sel = alu_slt;
            3'b011:  alu_sel = alu_sltu;
            3'b100:  alu_sel = alu_xor;
            3'b101:  alu_sel = funct7[5] ? alu_sra : alu_srl;
            3'b110:  alu_sel = alu_or;
            default: alu_sel = alu_and;
        endcase
        alu_ok = 1'b1;
        if (is_reg) begin
            alu_ok = (funct7 == 7'b0000000) ||
                     ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
        end else if (funct3 == 3'b001) begin
            alu_ok = (funct7 == 7'b0000000);
        end else if (funct3 == 3'b101) begin
            alu_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end
    end

    always_comb begin
        rs1_o       = instr_i[19:15];
        rs2_o       = instr_i[24:20];
        rd_o        = instr_i[11:7];
        imm_o       = imm_i_type;
        opcode_o    = op_nop;
        alu_op_o    = alu_add;
        use_imm_o   = 1'b0;
        writes_rd_o = 1'b0;
        mem_read_o  = 1'b0;
        mem_write_o = 1'b0;
        case (instr_i[6:0])
            op_imm: begin
                if (alu_ok) begin
                    opcode_o    = op_imm;
                    alu_op_o    = alu_sel;
                    use_imm_o   = 1'b1;
                    writes_rd_o = 1'b1;
                end
            end
            op_reg: begin
                if (alu_ok) begin
                    opcode_o    = op_reg;
                    alu_op_o    = alu_sel;
                    writes_rd_o = 1'b1;
                end
            end
            op_lui: begin
                // x0 + U immediate
                rs1_o       = '0;
                imm_o       = imm_u_type;
                opcode_o    = op_lui;
                use_imm_o   = 1'b1;
                writes_rd_o = 1'b1;
            end
            op_load: begin
                if (funct3 == 3'b010) begin
                    opcode_o    = op_load;
                    use_imm_o   = 1'b1;
                    writes_rd_o = 1'b1;
                    mem_read_o  = 1'b1;
                end
            end
            op_store: begin
                if (funct3 == 3'b010) begin
                    imm_o       = imm_s_type;
                    opcode_o    = op_store;
                    use_imm_o   = 1'b1;
                    mem_write_o = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/regfile.sv
`timescale 1ns/100ps
`default_nettype none

module regfile
import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    input  reg_addr_t rd_i,
    input  logic      we_i,
    input  word_t     wdata_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o
);

    word_t regs [1:31];

    function automatic word_t read_port(reg_addr_t addr, logic we, reg_addr_t wa, word_t wd,
                                        word_t stored);
        if (addr == '0) begin
            return '0;
        end
        // write-to-read bypass
        if (we && (wa == addr)) begin
            return wd;
        end
        return stored;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_i != '0)) begin
            regs[rd_i] <= wdata_i;
        end
    end

    always_comb begin
        rdata1_o = read_port(rs1_i, we_i, rd_i, wdata_i, (rs1_i == '0) ? '0 : regs[rs1_i]);
        rdata2_o = read_port(rs2_i, we_i, rd_i, wdata_i, (rs2_i == '0) ? '0 : regs[rs2_i]);
    end

endmodule

`default_nettype wire

// File: rtl/forwarding_unit.sv
`timescale 1ns/100ps
`default_nettype none

module forwarding_unit
import pipe_pkg::*;
(
    input  logic      ex_valid_i,
    input  logic      mem_valid_i,
    input  logic      wb_valid_i,
    input  opcode_t   ex_opcode_i,
    input  reg_addr_t ex_rs1_i,
    input  reg_addr_t ex_rs2_i,
    input  logic      mem_writes_rd_i,
    input  logic      mem_reads_dmem_i,
    input  reg_addr_t mem_rd_i,
    input  logic      wb_writes_rd_i,
    input  reg_addr_t wb_rd_i,
    output fwd_sel_t  fwd1_sel_o,
    output fwd_sel_t  fwd2_sel_o,
    output logic      no_hazard_o
);

    logic ex_reads_rs1;
    logic ex_reads_rs2;
    logic mem_writes;
    logic mem_loads;
    logic wb_writes;
    logic rs1_hit_mem;
    logic rs2_hit_mem;
    logic rs1_hit_wb;
    logic rs2_hit_wb;

    // which sources the EX instruction actually reads
    assign ex_reads_rs1 = ex_valid_i && ((ex_opcode_i == op_imm) || (ex_opcode_i == op_reg) ||
                                         (ex_opcode_i == op_load) || (ex_opcode_i == op_store));
    assign ex_reads_rs2 = ex_valid_i && ((ex_opcode_i == op_reg) || (ex_opcode_i == op_store));

    assign mem_writes = mem_valid_i && mem_writes_rd_i && (mem_rd_i != '0);
    assign mem_loads  = mem_valid_i && mem_reads_dmem_i && (mem_rd_i != '0);
    assign wb_writes  = wb_valid_i && wb_writes_rd_i && (wb_rd_i != '0);

    assign rs1_hit_mem = ex_reads_rs1 && (ex_rs1_i == mem_rd_i);
    assign rs2_hit_mem = ex_reads_rs2 && (ex_rs2_i == mem_rd_i);
    assign rs1_hit_wb  = ex_reads_rs1 && (ex_rs1_i == wb_rd_i);
    assign rs2_hit_wb  = ex_reads_rs2 && (ex_rs2_i == wb_rd_i);

    // MEM is the younger producer and wins over WB
    always_comb begin
        if (mem_writes && rs1_hit_mem) begin
            fwd1_sel_o = fwd_mem;
        end else if (wb_writes && rs1_hit_wb) begin
            fwd1_sel_o = fwd_wb;
        end else begin
            fwd1_sel_o = no_fwd;
        end

        if (mem_writes && rs2_hit_mem) begin
            fwd2_sel_o = fwd_mem;
        end else if (wb_writes && rs2_hit_wb) begin
            fwd2_sel_o = fwd_wb;
        end else begin
            fwd2_sel_o = no_fwd;
        end
    end

    // load data only exists in WB, so a consumer right behind a load must wait
    assign no_hazard_o = !(mem_loads && (rs1_hit_mem || rs2_hit_mem));

endmodule

`default_nettype wire

// File: rtl/hazard_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic accept_i,
    input  logic no_hazard_i,
    output logic id_valid_o,
    output logic ex_valid_o,
    output logic mem_valid_o,
    output logic wb_valid_o,
    output logic stall_o,
    output logic hold_o
);

    logic stall;
    logic accept;

    assign stall   = !no_hazard_i;
    assign accept  = accept_i && !stall;
    assign stall_o = stall;
    assign hold_o  = stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid_o  <= 1'b0;
            ex_valid_o  <= 1'b0;
            mem_valid_o <= 1'b0;
            wb_valid_o  <= 1'b0;
        end else begin
            // the load in MEM always moves on to WB
            wb_valid_o <= mem_valid_o;
            if (stall) begin
                // ID and EX hold, bubble into MEM
                mem_valid_o <= 1'b0;
            end else begin
                id_valid_o  <= accept;
                ex_valid_o  <= id_valid_o;
                mem_valid_o <= ex_valid_o;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/exec_alu.sv
`timescale 1ns/100ps
`default_nettype none

module exec_alu
import pipe_pkg::*;
(
    input  word_t    rs1_data_i,
    input  word_t    rs2_data_i,
    input  word_t    imm_i,
    input  word_t    mem_fwd_i,
    input  word_t    wb_fwd_i,
    input  fwd_sel_t fwd1_sel_i,
    input  fwd_sel_t fwd2_sel_i,
    input  logic     use_imm_i,
    input  alu_op_t  alu_op_i,
    output word_t    result_o,
    output word_t    store_data_o
);

    word_t      op1;
    word_t      op2_reg;
    word_t      op2;
    logic [4:0] shamt;

    function automatic word_t fwd_pick(fwd_sel_t sel, word_t reg_val, word_t mem_val,
                                       word_t wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign op1     = fwd_pick(fwd1_sel_i, rs1_data_i, mem_fwd_i, wb_fwd_i);
    assign op2_reg = fwd_pick(fwd2_sel_i, rs2_data_i, mem_fwd_i, wb_fwd_i);
    assign op2     = use_imm_i ? imm_i : op2_reg;
    assign shamt   = op2[4:0];

    // stores take rs2 before the immediate replaces it
    assign store_data_o = op2_reg;

    always_comb begin
        case (alu_op_i)
            alu_add:  result_o = op1 + op2;
            alu_sub:  result_o = op1 - op2;
            alu_sll:  result_o = op1 << shamt;
            alu_slt:  result_o = {31'b0, $signed(op1) < $signed(op2)};
            alu_sltu: result_o = {31'b0, op1 < op2};
            alu_xor:  result_o = op1 ^ op2;
            alu_srl:  result_o = op1 >> shamt;
            alu_sra:  result_o = word_t'($signed(op1) >>> shamt);
            alu_or:   result_o = op1 | op2;
            alu_and:  result_o = op1 & op2;
            default:  result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/data_mem.sv
`timescale 1ns/100ps
`default_nettype none

module data_mem
import pipe_pkg::*;
#(
    parameter int DMEM_WORDS = 64
)
(
    input  logic  clk,
    input  logic  rst,
    input  word_t addr_i,
    input  logic  read_i,
    input  logic  write_i,
    input  word_t wdata_i,
    output word_t rdata_o
);

    localparam int ADDR_W = $clog2(DMEM_WORDS);

    word_t             mem [DMEM_WORDS];
    logic [ADDR_W-1:0] index;

    // byte address to word index, upper bits dropped so it wraps
    assign index = addr_i[ADDR_W+1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            rdata_o <= '0;
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (write_i) begin
                mem[index] <= wdata_i;
            end
            if (read_i) begin
                rdata_o <= mem[index];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/pipe_core.sv
`timescale 1ns/100ps
`default_nettype none

module pipe_core
import pipe_pkg::*;
#(
    parameter int DMEM_WORDS = 64
)
(
    input  logic      clk,
    input  logic      rst,
    input  word_t     instr_i,
    input  logic      instr_valid_i,
    output logic      stall_o,
    output logic      wb_valid_o,
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o
);

    logic ex_valid, mem_valid, wb_stage_valid;
    logic hold, no_hazard, accept;

    // IF/ID
    word_t if_id_instr;

    // decode outputs
    reg_addr_t dec_rs1, dec_rs2, dec_rd;
    word_t     dec_imm;
    opcode_t   dec_opcode;
    alu_op_t   dec_alu_op;
    logic      dec_use_imm, dec_writes_rd, dec_mem_read, dec_mem_write;

    // ID/EX
    reg_addr_t id_ex_rs1, id_ex_rs2, id_ex_rd;
    word_t     id_ex_imm, id_ex_rs1_data, id_ex_rs2_data;
    opcode_t   id_ex_opcode;
    alu_op_t   id_ex_alu_op;
    logic      id_ex_use_imm, id_ex_writes_rd, id_ex_mem_read, id_ex_mem_write;

    // EX/MEM
    word_t     ex_mem_alu, ex_mem_store_data;
    reg_addr_t ex_mem_rd;
    logic      ex_mem_writes_rd, ex_mem_mem_read, ex_mem_mem_write;

    // MEM/WB
    word_t     mem_wb_alu;
    reg_addr_t mem_wb_rd;
    logic      mem_wb_writes_rd, mem_wb_mem_read;

    reg_addr_t rf_rs1, rf_rs2;
    word_t     rf_rdata1, rf_rdata2;
    word_t     alu_result, store_data, dmem_rdata, wb_value;
    fwd_sel_t  fwd1_sel, fwd2_sel;

    assign accept = instr_valid_i && !stall_o;

    always_ff @(posedge clk) begin
        if (accept) begin
            if_id_instr <= instr_i;
        end
    end

    instr_decode u_decode (
        .instr_i(if_id_instr), .rs1_o(dec_rs1), .rs2_o(dec_rs2), .rd_o(dec_rd),
        .imm_o(dec_imm), .opcode_o(dec_opcode), .alu_op_o(dec_alu_op),
        .use_imm_o(dec_use_imm), .writes_rd_o(dec_writes_rd),
        .mem_read_o(dec_mem_read), .mem_write_o(dec_mem_write)
    );

    // while stalled the EX operands are re-read so the write retiring in WB is not lost
    assign rf_rs1 = hold ? id_ex_rs1 : dec_rs1;
    assign rf_rs2 = hold ? id_ex_rs2 : dec_rs2;

    regfile u_regfile (
        .clk(clk), .rst(rst), .rs1_i(rf_rs1), .rs2_i(rf_rs2), .rd_i(mem_wb_rd),
        .we_i(wb_valid_o), .wdata_i(wb_value), .rdata1_o(rf_rdata1), .rdata2_o(rf_rdata2)
    );

    always_ff @(posedge clk) begin
        id_ex_rs1_data <= rf_rdata1;
        id_ex_rs2_data <= rf_rdata2;
        if (!hold) begin
            id_ex_rs1       <= dec_rs1;
            id_ex_rs2       <= dec_rs2;
            id_ex_rd        <= dec_rd;
            id_ex_imm       <= dec_imm;
            id_ex_opcode    <= dec_opcode;
            id_ex_alu_op    <= dec_alu_op;
            id_ex_use_imm   <= dec_use_imm;
            id_ex_writes_rd <= dec_writes_rd;
            id_ex_mem_read  <= dec_mem_read;
            id_ex_mem_write <= dec_mem_write;
        end
    end

    forwarding_unit u_fwd (
        .ex_valid_i(ex_valid), .mem_valid_i(mem_valid), .wb_valid_i(wb_stage_valid),
        .ex_opcode_i(id_ex_opcode), .ex_rs1_i(id_ex_rs1), .ex_rs2_i(id_ex_rs2),
        .mem_writes_rd_i(ex_mem_writes_rd), .mem_reads_dmem_i(ex_mem_mem_read),
        .mem_rd_i(ex_mem_rd), .wb_writes_rd_i(mem_wb_writes_rd), .wb_rd_i(mem_wb_rd),
        .fwd1_sel_o(fwd1_sel), .fwd2_sel_o(fwd2_sel), .no_hazard_o(no_hazard)
    );

    hazard_ctrl u_hazard (
        .clk(clk), .rst(rst), .accept_i(instr_valid_i), .no_hazard_i(no_hazard),
        .id_valid_o(), .ex_valid_o(ex_valid), .mem_valid_o(mem_valid),
        .wb_valid_o(wb_stage_valid), .stall_o(stall_o), .hold_o(hold)
    );

    exec_alu u_alu (
        .rs1_data_i(id_ex_rs1_data), .rs2_data_i(id_ex_rs2_data), .imm_i(id_ex_imm),
        .mem_fwd_i(ex_mem_alu), .wb_fwd_i(wb_value), .fwd1_sel_i(fwd1_sel),
        .fwd2_sel_i(fwd2_sel), .use_imm_i(id_ex_use_imm), .alu_op_i(id_ex_alu_op),
        .result_o(alu_result), .store_data_o(store_data)
    );

    // a stall turns EX/MEM into a bubble through the valid bit alone
    always_ff @(posedge clk) begin
        ex_mem_alu        <= alu_result;
        ex_mem_store_data <= store_data;
        ex_mem_rd         <= id_ex_rd;
        ex_mem_writes_rd  <= id_ex_writes_rd;
        ex_mem_mem_read   <= id_ex_mem_read;
        ex_mem_mem_write  <= id_ex_mem_write;
    end

    data_mem #(.DMEM_WORDS(DMEM_WORDS)) u_dmem (
        .clk(clk), .rst(rst), .addr_i(ex_mem_alu), .read_i(mem_valid && ex_mem_mem_read),
        .write_i(mem_valid && ex_mem_mem_write), .wdata_i(ex_mem_store_data),
        .rdata_o(dmem_rdata)
    );

    always_ff @(posedge clk) begin
        mem_wb_alu       <= ex_mem_alu;
        mem_wb_rd        <= ex_mem_rd;
        mem_wb_writes_rd <= ex_mem_writes_rd;
        mem_wb_mem_read  <= ex_mem_mem_read;
    end

    assign wb_value   = mem_wb_mem_read ? dmem_rdata : mem_wb_alu;
    assign wb_valid_o = wb_stage_valid && mem_wb_writes_rd && (mem_wb_rd != '0);
    assign wb_rd_o    = mem_wb_rd;
    assign wb_data_o  = wb_value;

endmodule

`default_nettype wire

// File: sim/tb_pipe_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pipe_core
import pipe_pkg::*;
;

    localparam int DMEM_WORDS = 64;
    localparam int N_INSTR    = 23 + 7 + 14 + 9 + 9 + 200;
    localparam int MAX_CYCLES = 6 * N_INSTR + 100;

    localparam logic [6:0] OPC_LOAD  = 7'h03;
    localparam logic [6:0] OPC_IMM   = 7'h13;
    localparam logic [6:0] OPC_STORE = 7'h23;
    localparam logic [6:0] OPC_REG   = 7'h33;
    localparam logic [6:0] OPC_LUI   = 7'h37;

    logic      clk;
    logic      rst;
    word_t     instr_i;
    logic      instr_valid_i;
    logic      stall_o;
    logic      wb_valid_o;
    reg_addr_t wb_rd_o;
    word_t     wb_data_o;

    word_t     model_regs [32];
    word_t     model_mem [DMEM_WORDS];
    reg_addr_t exp_rd_q[$];
    word_t     exp_data_q[$];
    word_t     rng_state;
    int        errors;
    int        checks;
    int        issued;
    int        cycles;
    int        stall_cnt;
    int        tests_run;
    int        tests_failed;
    int        last_errors;

    pipe_core #(.DMEM_WORDS(DMEM_WORDS)) UUT (
        .clk(clk), .rst(rst), .instr_i(instr_i), .instr_valid_i(instr_valid_i),
        .stall_o(stall_o), .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic word_t enc_i(logic [2:0] f3, reg_addr_t rd, reg_addr_t rs1,
                                    logic [11:0] imm);
        return {imm, rs1, f3, rd, OPC_IMM};
    endfunction

    function automatic word_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                    reg_addr_t rs1, reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_REG};
    endfunction

    function automatic word_t enc_lui(reg_addr_t rd, logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic word_t enc_lw(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, OPC_LOAD};
    endfunction

    function automatic word_t enc_sw(reg_addr_t rs2, reg_addr_t rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // legal encodings only, registers limited to x0..x3 so dependences are dense
    function automatic word_t random_instr();
        word_t       r;
        word_t       instr;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        r   = next_random();
        rd  = {3'b000, r[9:8]};
        rs1 = {3'b000, r[11:10]};
        rs2 = {3'b000, r[13:12]};
        f3  = r[16:14];
        imm = r[31:20];
        f7  = ((f3 == 3'd0) || (f3 == 3'd5)) ? {1'b0, r[17], 5'b0} : 7'h00;
        case (r[2:0])
            3'd0, 3'd1, 3'd2: begin
                if (f3 == 3'd1) begin
                    imm[11:5] = 7'h00;
                end else if (f3 == 3'd5) begin
                    imm[11:5] = f7;
                end
                instr = enc_i(f3, rd, rs1, imm);
            end
            3'd3, 3'd4: instr = enc_r(f7, f3, rd, rs1, rs2);
            3'd5:       instr = enc_lui(rd, r[31:12]);
            3'd6:       instr = enc_lw(rd, rs1, imm);
            default:    instr = enc_sw(rs2, rs1, imm);
        endcase
        return instr;
    endfunction

    // executes one instruction on the model state in program order
    function automatic void ref_exec(word_t instr);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        reg_addr_t  rd;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_s;
        word_t      res;
        logic       wr;
        int         idx;
        opc   = instr[6:0];
        f3    = instr[14:12];
        f7    = instr[31:25];
        rd    = instr[11:7];
        a     = model_regs[instr[19:15]];
        b     = model_regs[instr[24:20]];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        res   = '0;
        wr    = 1'b0;
        case (opc)
            OPC_IMM: begin
                wr = 1'b1;
                case (f3)
                    3'd0: res = a + imm_i;
                    3'd1: begin
                        res = a << imm_i[4:0];
                        wr  = (f7 == 7'h00);
                    end
                    3'd2: res = ($signed(a) < $signed(imm_i)) ? 32'd1 : 32'd0;
                    3'd3: res = (a < imm_i) ? 32'd1 : 32'd0;
                    3'd4: res = a ^ imm_i;
                    3'd5: begin
                        if (f7 == 7'h00) begin
                            res = a >> imm_i[4:0];
                        end else if (f7 == 7'h20) begin
                            res = $signed(a) >>> imm_i[4:0];
                        end else begin
                            wr = 1'b0;
                        end
                    end
                    3'd6: res = a | imm_i;
                    default: res = a & imm_i;
                endcase
            end
            OPC_REG: begin
                wr = 1'b1;
                case ({f7, f3})
                    {7'h00, 3'd0}: res = a + b;
                    {7'h20, 3'd0}: res = a - b;
                    {7'h00, 3'd1}: res = a << b[4:0];
                    {7'h00, 3'd2}: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    {7'h00, 3'd3}: res = (a < b) ? 32'd1 : 32'd0;
                    {7'h00, 3'd4}: res = a ^ b;
                    {7'h00, 3'd5}: res = a >> b[4:0];
                    {7'h20, 3'd5}: res = $signed(a) >>> b[4:0];
                    {7'h00, 3'd6}: res = a | b;
                    {7'h00, 3'd7}: res = a & b;
                    default:       wr = 1'b0;
                endcase
            end
            OPC_LUI: begin
                res = {instr[31:12], 12'b0};
                wr  = 1'b1;
            end
            OPC_LOAD: begin
                if (f3 == 3'd2) begin
                    idx = int'(((a + imm_i) >> 2) % DMEM_WORDS);
                    res = model_mem[idx];
                    wr  = 1'b1;
                end
            end
            OPC_STORE: begin
                if (f3 == 3'd2) begin
                    idx = int'(((a + imm_s) >> 2) % DMEM_WORDS);
                    model_mem[idx] = b;
                end
            end
            default: ;
        endcase
        if (wr && (rd != '0)) begin
            model_regs[rd] = res;
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(res);
        end
    endfunction

    task automatic check_rd(input reg_addr_t got, input reg_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: writeback to x%0d, expected x%0d", $time, got, exp);
        end
    endtask

    task automatic check_data(input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: writeback data %h, expected %h", $time, got, exp);
        end
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic issue(input word_t instr);
        instr_i       = instr;
        instr_valid_i = 1'b1;
        while (stall_o) begin
            @(negedge clk);
        end
        @(negedge clk);
        instr_valid_i = 1'b0;
        issued++;
        ref_exec(instr);
    endtask

    // five edges cover the longest path of a non-writing instruction plus one stall
    task automatic drain();
        while (exp_rd_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (5) @(negedge clk);
    endtask

    task automatic end_test(input string name);
        drain();
        tests_run++;
        if (errors != last_errors) begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - last_errors);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        last_errors = errors;
    endtask

    always @(negedge clk) begin
        if (!rst && wb_valid_o) begin
            if (exp_rd_q.size() == 0) begin
                errors++;
                $display("extra retirement of x%0d = %h at %0t with no write expected",
                         wb_rd_o, wb_data_o, $time);
            end else begin
                check_rd(wb_rd_o, exp_rd_q.pop_front());
                check_data(wb_data_o, exp_data_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (!rst && stall_o) begin
            stall_cnt++;
        end
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d issued, %0d retirements missing",
                     cycles, issued, N_INSTR, exp_rd_q.size());
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        rst           = 1'b1;
        instr_i       = '0;
        instr_valid_i = 1'b0;
        rng_state     = 32'h1121_7275;
        errors        = 0;
        checks        = 0;
        issued        = 0;
        cycles        = 0;
        stall_cnt     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        last_errors   = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;

        // independent ALU work, sources settled in the register file
        issue(enc_i(3'd0, 1, 0, 5));
        issue(enc_i(3'd0, 2, 0, -3));
        issue(enc_lui(3, 20'h80001));
        issue(enc_i(3'd6, 4, 0, 12'h7f0));
        issue(enc_i(3'd0, 0, 0, 123));
        issue(32'h0000_0000);
        issue(32'h0000_0000);
        issue(32'h0000_0000);
        issue(enc_r(7'h00, 3'd0, 5, 1, 2));
        issue(enc_r(7'h20, 3'd0, 6, 1, 2));
        issue(enc_r(7'h00, 3'd1, 7, 3, 1));
        issue(enc_r(7'h00, 3'd2, 8, 2, 1));
        issue(enc_r(7'h00, 3'd3, 9, 2, 1));
        issue(enc_r(7'h00, 3'd4, 10, 3, 4));
        issue(enc_r(7'h00, 3'd5, 11, 3, 1));
        issue(enc_r(7'h20, 3'd5, 12, 3, 1));
        issue(enc_r(7'h00, 3'd6, 13, 3, 4));
        issue(enc_r(7'h00, 3'd7, 14, 2, 4));
        issue(enc_i(3'd2, 15, 2, -2));
        issue(enc_i(3'd3, 16, 1, -1));
        issue(enc_i(3'd4, 17, 4, 12'h0ff));
        issue(enc_i(3'd1, 18, 2, 12'd4));
        issue(enc_i(3'd5, 19, 2, 12'h404));
        end_test("independent alu");

        // back to back, then MEM over WB on the same register
        issue(enc_i(3'd0, 1, 0, 10));
        issue(enc_i(3'd0, 2, 1, 3));
        issue(enc_r(7'h00, 3'd0, 3, 0, 2));
        issue(enc_r(7'h00, 3'd0, 4, 3, 3));
        issue(enc_i(3'd0, 5, 0, 1));
        issue(enc_i(3'd0, 5, 0, 2));
        issue(enc_r(7'h00, 3'd0, 6, 5, 5));
        end_test("mem forwarding");

        issue(enc_i(3'd0, 7, 0, 100));
        issue(enc_i(3'd0, 8, 0, 1));
        issue(enc_r(7'h00, 3'd0, 9, 7, 0));
        issue(enc_i(3'd0, 10, 0, 5));
        issue(enc_i(3'd0, 11, 0, 6));
        issue(enc_r(7'h20, 3'd0, 12, 0, 10));
        issue(enc_i(3'd0, 13, 0, 77));
        issue(enc_i(3'd0, 14, 0, 1));
        issue(enc_i(3'd0, 15, 0, 2));
        issue(enc_r(7'h00, 3'd0, 16, 13, 13));
        issue(enc_i(3'd0, 17, 0, 9));
        issue(enc_i(3'd0, 18, 0, 0));
        issue(enc_i(3'd0, 0, 0, 0));
        issue(enc_r(7'h00, 3'd6, 19, 0, 17));
        end_test("wb forwarding and bypass");

        stall_cnt = 0;
        issue(enc_i(3'd0, 1, 0, 12'h055));
        issue(enc_sw(1, 0, 8));
        issue(enc_lw(2, 0, 8));
        issue(enc_r(7'h00, 3'd0, 3, 2, 2));
        issue(enc_i(3'd0, 20, 0, 3));
        issue(enc_lw(6, 0, 8));
        issue(enc_r(7'h20, 3'd0, 7, 0, 6));
        drain();
        if (stall_cnt == 0) begin
            errors++;
            $display("stall_o never rose for a load followed by a consumer of its result");
        end
        stall_cnt = 0;
        issue(enc_lw(4, 0, 8));
        issue(enc_i(3'd0, 5, 1, 1));
        drain();
        if (stall_cnt != 0) begin
            errors++;
            $display("stall_o rose %0d times after a load with no dependent instruction",
                     stall_cnt);
        end
        end_test("load use");

        // 256 bytes wraps to word 0 with 64 words
        issue(enc_i(3'd0, 1, 0, 12'h123));
        issue(enc_i(3'd0, 2, 0, -77));
        issue(enc_sw(1, 0, 0));
        issue(enc_sw(2, 0, 4));
        issue(enc_lw(3, 0, 0));
        issue(enc_lw(4, 0, 4));
        issue(enc_lw(5, 0, 12));
        issue(enc_sw(1, 0, 260));
        issue(enc_lw(6, 0, 4));
        end_test("store and load");

        for (int i = 0; i < 200; i++) begin
            issue(random_instr());
        end
        end_test("random mix");

        $display("tests %0d, failed %0d, instructions %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, issued, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
rtl/pipe_pkg.sv
rtl/instr_decode.sv
rtl/regfile.sv
rtl/forwarding_unit.sv
rtl/hazard_ctrl.sv
rtl/exec_alu.sv
rtl/data_mem.sv
rtl/pipe_core.sv
sim/tb_pipe_core.sv

// File: Bender.yml
package:
  name: pipe_core

sources:
  - rtl/pipe_pkg.sv
  - rtl/instr_decode.sv
  - rtl/regfile.sv
  - rtl/forwarding_unit.sv
  - rtl/hazard_ctrl.sv
  - rtl/exec_alu.sv
  - rtl/data_mem.sv
  - rtl/pipe_core.sv
  - target: test
    files:
      - sim/tb_pipe_core.sv
